/* hdl/lsu_cfg.svh */
// load/store unit configuration
// bus width, queue depth and instruction ID width

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// memory bus word in bits and bytes
`define LSU_VMEM_W 32
`define LSU_VMEM_B (`LSU_VMEM_W / 8)

// byte offset inside one bus word
`define LSU_OFF_W ($clog2(`LSU_VMEM_B))

// instruction ID width
`define LSU_ID_W 3

// entries in the pending request queue
`define LSU_QUEUE_SZ 4

`endif

/* hdl/lsu_pkg.sv */
// load/store unit types
// command, pending entry, result and completion records

`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic {
        LSU_UNITSTRIDE = 1'b0,
        LSU_STRIDED    = 1'b1
    } lsu_stride_e;

    typedef enum logic [1:0] {
        LSU_EEW_8  = 2'd0,
        LSU_EEW_16 = 2'd1,
        LSU_EEW_32 = 2'd2
    } lsu_eew_e;

    // one command per memory word
    typedef struct packed {
        logic                     first;
        logic                     last;
        logic [`LSU_ID_W-1:0]     id;
        logic                     store;
        lsu_stride_e              stride;
        lsu_eew_e                 eew;
        logic                     masked;
        logic                     init_addr;
        // base address when init_addr is set, stride otherwise
        logic [31:0]              xval;
        logic [`LSU_OFF_W-1:0]    vl_part;
        logic                     vl_part_0;
        logic [`LSU_VMEM_W-1:0]   wdata;
        logic [`LSU_VMEM_B-1:0]   vmask;
    } lsu_cmd_t;

    // what an in-flight request still needs once its data returns
    typedef struct packed {
        logic [`LSU_ID_W-1:0]     id;
        logic                     first;
        logic                     last;
        logic                     store;
        lsu_stride_e              stride;
        lsu_eew_e                 eew;
        logic                     masked;
        logic [`LSU_OFF_W-1:0]    vl_part;
        logic                     vl_part_0;
        logic                     suppressed;
        logic [`LSU_OFF_W-1:0]    off;
        logic [`LSU_VMEM_B-1:0]   vmask;
    } lsu_pend_t;

    typedef struct packed {
        logic [`LSU_ID_W-1:0]     id;
        logic                     first;
        logic                     last;
        logic [`LSU_VMEM_W-1:0]   data;
        logic [`LSU_VMEM_B-1:0]   mask;
        logic                     err;
    } lsu_res_t;

    typedef struct packed {
        logic [`LSU_ID_W-1:0]     id;
        logic                     exc;
        logic [5:0]               exccode;
    } lsu_cpl_t;

    localparam logic [5:0] LSU_EXC_LOAD_FAULT  = 6'd5;
    localparam logic [5:0] LSU_EXC_STORE_FAULT = 6'd7;

    // bytes 0 through vl_part, none when no element is valid
    function automatic logic [`LSU_VMEM_B-1:0] lsu_vl_mask(
        logic [`LSU_OFF_W-1:0] vl_part,
        logic                  vl_part_0
    );
        return vl_part_0 ? '0 : ({`LSU_VMEM_B{1'b1}} >> ~vl_part);
    endfunction

    // byte offset rounded down to the element width
    function automatic logic [`LSU_OFF_W-1:0] lsu_elem_off(
        logic [`LSU_OFF_W-1:0] off,
        lsu_eew_e              eew
    );
        return off & ({`LSU_OFF_W{1'b1}} << eew);
    endfunction

endpackage

/* hdl/mem_bus_pkg.sv */
// memory bus records
// request and result words of the vector memory interface

`include "lsu_cfg.svh"

package mem_bus_pkg;

    // one bus request, addr is always word aligned
    typedef struct packed {
        logic [`LSU_ID_W-1:0]     id;
        logic [31:0]              addr;
        logic                     we;
        logic [`LSU_VMEM_B-1:0]   be;
        logic [`LSU_VMEM_W-1:0]   wdata;
        logic                     last;
    } mem_req_t;

    // results return in request order and cannot be stalled
    typedef struct packed {
        logic [`LSU_ID_W-1:0]     id;
        logic [`LSU_VMEM_W-1:0]   rdata;
        logic                     err;
    } mem_res_t;

endpackage

/* hdl/lsu_fifo.sv */
// first-in first-out queue on a ring buffer
// data flows straight through when the queue is empty

`timescale 1ns/1ps

module lsu_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             async_rst_ni,

    input  logic             enq_valid_i,
    output logic             enq_ready_o,
    input  logic [WIDTH-1:0] enq_data_i,

    output logic             deq_valid_o,
    input  logic             deq_ready_i,
    output logic [WIDTH-1:0] deq_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = PTR_W + 1;

    logic [WIDTH-1:0] buf_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             empty, flow, push, pop;

    assign empty       = (cnt_q == '0);
    assign enq_ready_o = (cnt_q != CNT_W'(DEPTH));
    assign deq_valid_o = ~empty | enq_valid_i;
    assign deq_data_o  = empty ? enq_data_i : buf_q[rd_ptr_q];

    // an entry that passes straight through is never stored
    assign flow = empty & enq_valid_i & deq_ready_i;
    assign push = enq_valid_i & enq_ready_o & ~flow;
    assign pop  = deq_ready_i & ~empty;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= enq_data_i;
        end
    end

endmodule

/* hdl/lsu_req_stage.sv */
// load/store request stage
// builds address, store data and byte enables, then holds the bus request

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_stage import lsu_pkg::*, mem_bus_pkg::*; (
    input  logic      clk_i,
    input  logic      async_rst_ni,

    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    input  lsu_cmd_t  cmd_i,

    output logic      mem_valid_o,
    input  logic      mem_ready_i,
    output mem_req_t  mem_req_o,

    output logic      pend_valid_o,
    input  logic      pend_ready_i,
    output lsu_pend_t pend_o
);

    localparam int unsigned VMEM_W = `LSU_VMEM_W;
    localparam int unsigned VMEM_B = `LSU_VMEM_B;
    localparam int unsigned OFF_W  = `LSU_OFF_W;

    logic              valid_q;
    logic              stage_ready;
    logic [31:0]       addr_q, addr_d;
    logic [VMEM_W-1:0] wdata_q, wdata_d, wdata_rep;
    logic [VMEM_B-1:0] be_q, be_d, elem_be;
    logic [OFF_W-1:0]  elem_off;
    logic              elem_act;
    lsu_pend_t         pend_q, pend_d;

    //////////////////////////////
    // handshake

    // the register empties on a bus handshake or when a suppressed entry retires
    assign mem_valid_o  = valid_q & ~pend_q.suppressed & pend_ready_i;
    assign pend_valid_o = valid_q & (pend_q.suppressed | mem_ready_i);
    assign stage_ready  = ~valid_q | (pend_valid_o & pend_ready_i);
    assign cmd_ready_o  = stage_ready;

    //////////////////////////////
    // address and store data

    always_comb begin
        if (cmd_i.init_addr) begin
            addr_d = cmd_i.xval;
        end else if (cmd_i.stride == LSU_UNITSTRIDE) begin
            addr_d = addr_q + 32'(VMEM_B);
        end else begin
            addr_d = addr_q + cmd_i.xval;
        end
    end

    assign elem_off = lsu_elem_off(addr_d[OFF_W-1:0], cmd_i.eew);
    assign elem_act = ~cmd_i.vl_part_0 & (~cmd_i.masked | cmd_i.vmask[0]);

    // strided stores replicate the low element over the whole word
    always_comb begin
        case (cmd_i.eew)
            LSU_EEW_8: begin
                wdata_rep = {VMEM_B{cmd_i.wdata[7:0]}};
                elem_be   = VMEM_B'(4'b0001);
            end
            LSU_EEW_16: begin
                wdata_rep = {(VMEM_B / 2){cmd_i.wdata[15:0]}};
                elem_be   = VMEM_B'(4'b0011);
            end
            default: begin
                wdata_rep = {(VMEM_B / 4){cmd_i.wdata[31:0]}};
                elem_be   = VMEM_B'(4'b1111);
            end
        endcase
    end

    always_comb begin
        if (cmd_i.stride == LSU_UNITSTRIDE) begin
            wdata_d = cmd_i.wdata;
            be_d    = (cmd_i.masked ? cmd_i.vmask : '1)
                    & lsu_vl_mask(cmd_i.vl_part, cmd_i.vl_part_0);
        end else begin
            wdata_d = wdata_rep;
            be_d    = elem_act ? (elem_be << elem_off) : '0;
        end
    end

    always_comb begin
        pend_d            = '0;
        pend_d.id         = cmd_i.id;
        pend_d.first      = cmd_i.first;
        pend_d.last       = cmd_i.last;
        pend_d.store      = cmd_i.store;
        pend_d.stride     = cmd_i.stride;
        pend_d.eew        = cmd_i.eew;
        pend_d.masked     = cmd_i.masked;
        pend_d.vl_part    = cmd_i.vl_part;
        pend_d.vl_part_0  = cmd_i.vl_part_0;
        // no active element, so nothing goes to the bus
        pend_d.suppressed = cmd_i.vl_part_0;
        pend_d.off        = addr_d[OFF_W-1:0];
        pend_d.vmask      = cmd_i.vmask;
    end

    //////////////////////////////
    // request register

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (stage_ready) begin
            valid_q <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_ready & cmd_valid_i) begin
            addr_q  <= addr_d;
            wdata_q <= wdata_d;
            be_q    <= be_d;
            pend_q  <= pend_d;
        end
    end

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.id    = pend_q.id;
        mem_req_o.addr  = {addr_q[31:OFF_W], {OFF_W{1'b0}}};
        mem_req_o.we    = pend_q.store;
        mem_req_o.be    = be_q;
        mem_req_o.wdata = wdata_q;
        mem_req_o.last  = pend_q.last;
    end

    assign pend_o = pend_q;

endmodule

/* hdl/lsu_resp_stage.sv */
// load/store response stage
// matches bus results to pending entries, forms result words and completions

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_resp_stage import lsu_pkg::*, mem_bus_pkg::*; (
    input  logic      clk_i,
    input  logic      async_rst_ni,

    input  logic      pend_valid_i,
    output logic      pend_ready_o,
    input  lsu_pend_t pend_i,

    input  logic      mem_res_valid_i,
    input  mem_res_t  mem_res_i,

    output logic      res_valid_o,
    output lsu_res_t  res_o,

    output logic      cpl_valid_o,
    input  logic      cpl_ready_i,
    output lsu_cpl_t  cpl_o
);

    localparam int unsigned VMEM_W = `LSU_VMEM_W;
    localparam int unsigned VMEM_B = `LSU_VMEM_B;
    localparam int unsigned OFF_W  = `LSU_OFF_W;

    logic              match, pop, cpl_space, cpl_enq_ready;
    logic              err_q, err_d;
    logic [5:0]        code_q, code_d;
    logic              res_valid_q, res_err_q;
    lsu_pend_t         ent_q;
    logic [VMEM_W-1:0] rdata_q, shifted, data;
    logic [VMEM_B-1:0] mask;
    logic [OFF_W-1:0]  elem_off;
    logic              elem_act;
    logic              cpl_vld_q;
    lsu_cpl_t          cpl_q, cpl_d;

    //////////////////////////////
    // dequeue and error tracking

    assign match     = mem_res_valid_i & (mem_res_i.id == pend_i.id);
    // the completion register frees up when the queue takes its entry
    assign cpl_space = ~cpl_vld_q | cpl_enq_ready;

    assign pend_ready_o = (pend_i.suppressed | match) & (~pend_i.last | cpl_space);
    assign pop          = pend_valid_i & pend_ready_o;

    // sticky per instruction, cleared by the first entry
    always_comb begin
        err_d  = err_q;
        code_d = code_q;
        if (pop & (pend_i.first | ~err_q)) begin
            err_d  = ~pend_i.suppressed & mem_res_i.err;
            code_d = '0;
            if (err_d) begin
                code_d = pend_i.store ? LSU_EXC_STORE_FAULT : LSU_EXC_LOAD_FAULT;
            end
        end
    end

    always_comb begin
        cpl_d         = '0;
        cpl_d.id      = pend_i.id;
        cpl_d.exc     = err_d;
        cpl_d.exccode = code_d;
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            err_q       <= 1'b0;
            code_q      <= '0;
            res_valid_q <= 1'b0;
            cpl_vld_q   <= 1'b0;
        end else begin
            err_q       <= err_d;
            code_q      <= code_d;
            res_valid_q <= pop;
            if (cpl_space) begin
                cpl_vld_q <= pop & pend_i.last;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            ent_q     <= pend_i;
            rdata_q   <= mem_res_i.rdata;
            res_err_q <= err_d;
        end
        if (pop & pend_i.last) begin
            cpl_q <= cpl_d;
        end
    end

    lsu_fifo #(
        .WIDTH        ($bits(lsu_cpl_t)),
        .DEPTH        (2)
    ) i_cpl_fifo (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .enq_valid_i  (cpl_vld_q),
        .enq_ready_o  (cpl_enq_ready),
        .enq_data_i   (cpl_q),
        .deq_valid_o  (cpl_valid_o),
        .deq_ready_i  (cpl_ready_i),
        .deq_data_o   (cpl_o)
    );

    //////////////////////////////
    // result word

    assign elem_off = lsu_elem_off(ent_q.off, ent_q.eew);
    assign shifted  = rdata_q >> {elem_off, 3'b000};
    assign elem_act = ~ent_q.vl_part_0 & (~ent_q.masked | ent_q.vmask[0]);

    always_comb begin
        data = '0;
        mask = '0;
        // stores give no data back
        if (~ent_q.store) begin
            if (ent_q.stride == LSU_UNITSTRIDE) begin
                data = rdata_q;
                mask = (ent_q.masked ? ent_q.vmask : '1)
                     & lsu_vl_mask(ent_q.vl_part, ent_q.vl_part_0);
            end else begin
                case (ent_q.eew)
                    LSU_EEW_8:  data = VMEM_W'(shifted[7:0]);
                    LSU_EEW_16: data = VMEM_W'(shifted[15:0]);
                    default:    data = VMEM_W'(shifted[31:0]);
                endcase
                mask = {VMEM_B{elem_act}};
            end
        end
    end

    assign res_valid_o = res_valid_q;

    always_comb begin
        res_o       = '0;
        res_o.id    = ent_q.id;
        res_o.first = ent_q.first;
        res_o.last  = ent_q.last;
        res_o.data  = data;
        res_o.mask  = mask;
        res_o.err   = res_err_q;
    end

endmodule

/* hdl/vec_lsu.sv */
// vector load/store unit
// request stage, pending request queue and response stage

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module vec_lsu import lsu_pkg::*, mem_bus_pkg::*; (
    input  logic     clk_i,
    input  logic     async_rst_ni,

    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,
    input  lsu_cmd_t cmd_i,

    output logic     mem_valid_o,
    input  logic     mem_ready_i,
    output mem_req_t mem_req_o,
    input  logic     mem_res_valid_i,
    input  mem_res_t mem_res_i,

    output logic     res_valid_o,
    output lsu_res_t res_o,

    output logic     cpl_valid_o,
    input  logic     cpl_ready_i,
    output lsu_cpl_t cpl_o
);

    logic      enq_valid, enq_ready;
    lsu_pend_t enq_ent;
    logic      head_valid, head_ready;
    lsu_pend_t head_ent;

    lsu_req_stage i_req_stage (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_i        (cmd_i),
        .mem_valid_o  (mem_valid_o),
        .mem_ready_i  (mem_ready_i),
        .mem_req_o    (mem_req_o),
        .pend_valid_o (enq_valid),
        .pend_ready_i (enq_ready),
        .pend_o       (enq_ent)
    );

    // in-flight requests, one entry per bus word
    lsu_fifo #(
        .WIDTH        ($bits(lsu_pend_t)),
        .DEPTH        (`LSU_QUEUE_SZ)
    ) i_pend_fifo (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .enq_valid_i  (enq_valid),
        .enq_ready_o  (enq_ready),
        .enq_data_i   (enq_ent),
        .deq_valid_o  (head_valid),
        .deq_ready_i  (head_ready),
        .deq_data_o   (head_ent)
    );

    lsu_resp_stage i_resp_stage (
        .clk_i           (clk_i),
        .async_rst_ni    (async_rst_ni),
        .pend_valid_i    (head_valid),
        .pend_ready_o    (head_ready),
        .pend_i          (head_ent),
        .mem_res_valid_i (mem_res_valid_i),
        .mem_res_i       (mem_res_i),
        .res_valid_o     (res_valid_o),
        .res_o           (res_o),
        .cpl_valid_o     (cpl_valid_o),
        .cpl_ready_i     (cpl_ready_i),
        .cpl_o           (cpl_o)
    );

endmodule

/* verif/tb_clk_gen.sv */
// testbench clock generator
// free running clock, 40 ns period

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int unsigned HALF_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

endmodule

/* verif/tb_vec_lsu.sv */
// testbench for the vector load/store unit
// directed tests against a bus memory model with random ready and latency

`timescale 1ns/1ps

module tb_vec_lsu import lsu_pkg::*, mem_bus_pkg::*; ();

    // commands per test, in the order the tests run
    localparam int NUM_CMDS = 5 + 8 + 4 + 8 + 5 + 5;

    logic     clk, rst_n;
    logic     cmd_valid, cmd_ready;
    lsu_cmd_t cmd;
    logic     mem_valid, mem_ready;
    mem_req_t mem_req;
    logic     mem_res_valid;
    mem_res_t mem_res;
    logic     res_valid;
    lsu_res_t res;
    logic     cpl_valid, cpl_ready;
    lsu_cpl_t cpl;

    // expected traffic, filled as commands are issued
    mem_req_t    exp_reqs[$];
    lsu_res_t    exp_res[$];
    lsu_cpl_t    exp_cpls[$];
    // sticky error of the instruction being issued
    logic        exp_err;
    logic        hold_mem;
    int unsigned due_q[$];
    mem_res_t    bus_res_q[$];

    tb_clk_gen i_clk_gen (
        .clk_o (clk)
    );

    vec_lsu i_vec_lsu (
        .clk_i           (clk),
        .async_rst_ni    (rst_n),
        .cmd_valid_i     (cmd_valid),
        .cmd_ready_o     (cmd_ready),
        .cmd_i           (cmd),
        .mem_valid_o     (mem_valid),
        .mem_ready_i     (mem_ready),
        .mem_req_o       (mem_req),
        .mem_res_valid_i (mem_res_valid),
        .mem_res_i       (mem_res),
        .res_valid_o     (res_valid),
        .res_o           (res),
        .cpl_valid_o     (cpl_valid),
        .cpl_ready_i     (cpl_ready),
        .cpl_o           (cpl)
    );

    //////////////////////////////
    // reporting

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // memory model

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr >> 2) ^ 32'hC35A_0F96;
    endfunction

    // one 256 byte page faults on every access
    function automatic logic in_err_range(input logic [31:0] addr);
        return addr[31:8] == 24'h000030;
    endfunction

    initial begin : memory_model
        int unsigned cyc;
        int unsigned last_due;
        int unsigned due;
        logic        waiting;
        mem_req_t    held;
        mem_res_t    r;
        cyc           = 0;
        last_due      = 0;
        waiting       = 1'b0;
        held          = '0;
        mem_ready     = 1'b0;
        mem_res_valid = 1'b0;
        mem_res       = '0;
        void'($urandom(34416));
        forever begin
            @(negedge clk);
            // a waiting request must not change
            if (waiting && mem_valid) begin
                check_value("mem_req_o", mem_req, held);
            end
            waiting = mem_valid && !mem_ready;
            held    = mem_req;
            if (mem_valid && mem_ready) begin
                if (exp_reqs.size() == 0) begin
                    fail_run("bus request seen with no command that should make one");
                end else begin
                    check_value("mem_req_o", mem_req, exp_reqs.pop_front());
                end
                r.id    = mem_req.id;
                r.rdata = mem_word(mem_req.addr);
                r.err   = in_err_range(mem_req.addr);
                due     = cyc + 1 + ($urandom % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                due_q.push_back(due);
                bus_res_q.push_back(r);
            end
            @(posedge clk);
            cyc++;
            #1;
            mem_ready = !hold_mem && (($urandom % 4) != 0);
            if (due_q.size() != 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                mem_res_valid = 1'b1;
                mem_res       = bus_res_q.pop_front();
            end else begin
                mem_res_valid = 1'b0;
                mem_res       = '0;
            end
        end
    end

    //////////////////////////////
    // output monitors

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (res_valid) begin
                if (exp_res.size() == 0) begin
                    fail_run("result word seen with no outstanding command");
                end else begin
                    check_value("res_o", res, exp_res.pop_front());
                end
            end
            if (cpl_valid && cpl_ready) begin
                if (exp_cpls.size() == 0) begin
                    fail_run("completion seen with no finished instruction");
                end else begin
                    check_value("cpl_o", cpl, exp_cpls.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_CMDS * 20) @(posedge clk);
        fail_run($sformatf("timeout, traffic still outstanding after %0d cycles",
                           NUM_CMDS * 20));
    end

    //////////////////////////////
    // stimulus

    function automatic lsu_cmd_t make_cmd(
        input logic [2:0]  id,
        input logic        first,
        input logic        last,
        input logic        store,
        input lsu_stride_e stride,
        input lsu_eew_e    eew,
        input logic [31:0] xval,
        input logic [3:0]  vmask,
        input logic [1:0]  vl_part,
        input logic [31:0] wdata
    );
        lsu_cmd_t c;
        c           = '0;
        c.first     = first;
        c.last      = last;
        c.id        = id;
        c.store     = store;
        c.stride    = stride;
        c.eew       = eew;
        c.masked    = (vmask != 4'hF);
        c.init_addr = first;
        c.xval      = xval;
        c.vl_part   = vl_part;
        c.wdata     = wdata;
        c.vmask     = vmask;
        return c;
    endfunction

    // called a little after a rising edge, returns likewise
    task automatic drive_cmd(input lsu_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic expect_and_send(input lsu_cmd_t c, input logic [31:0] addr);
        int unsigned w;
        logic [1:0]  eoff;
        logic        act;
        logic        err;
        logic [3:0]  lmask;
        logic [31:0] rd;
        mem_req_t    rq;
        lsu_res_t    rs;
        lsu_cpl_t    cp;
        w    = 1 << c.eew;
        eoff = addr[1:0] & ~2'(w - 1);
        act  = !c.vl_part_0 && (!c.masked || c.vmask[0]);
        err  = !c.vl_part_0 && in_err_range(addr);
        rd   = mem_word(addr);
        for (int i = 0; i < 4; i++) begin
            lmask[i] = !c.vl_part_0 && (i <= c.vl_part);
        end
        rq       = '0;
        rq.id    = c.id;
        rq.addr  = {addr[31:2], 2'b00};
        rq.we    = c.store;
        rq.last  = c.last;
        rs       = '0;
        rs.id    = c.id;
        rs.first = c.first;
        rs.last  = c.last;
        if (c.stride == LSU_UNITSTRIDE) begin
            rq.wdata = c.wdata;
            rq.be    = (c.masked ? c.vmask : 4'hF) & lmask;
            rs.data  = rd;
            rs.mask  = rq.be;
        end else begin
            for (int i = 0; i < 4; i++) begin
                rq.wdata[8*i +: 8] = c.wdata[8*(i % w) +: 8];
            end
            rq.be   = act ? 4'(((1 << w) - 1) << eoff) : 4'h0;
            rs.data = (rd >> (8 * eoff)) & (32'hFFFF_FFFF >> (32 - 8 * w));
            rs.mask = act ? 4'hF : 4'h0;
        end
        // stores return nothing
        if (c.store) begin
            rs.data = '0;
            rs.mask = '0;
        end
        exp_err = c.first ? err : (exp_err | err);
        rs.err  = exp_err;
        if (!c.vl_part_0) begin
            exp_reqs.push_back(rq);
        end
        exp_res.push_back(rs);
        if (c.last) begin
            cp         = '0;
            cp.id      = c.id;
            cp.exc     = exp_err;
            cp.exccode = exp_err ? (c.store ? 6'd7 : 6'd5) : 6'd0;
            exp_cpls.push_back(cp);
        end
        drive_cmd(c);
    endtask

    // one instruction of n words, word 1 carries a partial mask
    task automatic send_insn(input logic [2:0] id, input logic store,
                             input lsu_stride_e stride, input lsu_eew_e eew,
                             input logic [31:0] base, input logic [31:0] step,
                             input int n, input logic [1:0] last_vl);
        logic [31:0] a;
        lsu_cmd_t    c;
        a = base;
        for (int i = 0; i < n; i++) begin
            c = make_cmd(id, i == 0, i == n - 1, store, stride, eew,
                         (i == 0) ? base : step, (i == 1) ? 4'b1010 : 4'hF,
                         (i == n - 1) ? last_vl : 2'd3, (32'h1357_9BDF * (i + 1)) ^ base);
            expect_and_send(c, a);
            a = a + step;
        end
    endtask

    task automatic wait_idle();
        while (exp_reqs.size() != 0 || exp_res.size() != 0 || exp_cpls.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // directed tests

    task automatic unit_stride_store();
        lsu_cmd_t c;
        send_insn(3'd1, 1'b1, LSU_UNITSTRIDE, LSU_EEW_32, 32'h100, 32'd4, 4, 2'd2);
        wait_idle();
        // no active element, so the bus must stay quiet
        c = make_cmd(3'd2, 1'b1, 1'b1, 1'b1, LSU_UNITSTRIDE, LSU_EEW_32, 32'h180,
                     4'hF, 2'd3, 32'hDEAD_BEEF);
        c.vl_part_0 = 1'b1;
        expect_and_send(c, 32'h180);
        wait_idle();
    endtask

    task automatic strided_store();
        send_insn(3'd3, 1'b1, LSU_STRIDED, LSU_EEW_8, 32'h201, 32'd3, 4, 2'd3);
        send_insn(3'd4, 1'b1, LSU_STRIDED, LSU_EEW_16, 32'h302, 32'd6, 4, 2'd3);
        wait_idle();
    endtask

    task automatic unit_stride_load();
        send_insn(3'd5, 1'b0, LSU_UNITSTRIDE, LSU_EEW_32, 32'h400, 32'd4, 4, 2'd1);
        wait_idle();
    endtask

    task automatic strided_load();
        send_insn(3'd6, 1'b0, LSU_STRIDED, LSU_EEW_16, 32'h502, 32'd6, 4, 2'd3);
        send_insn(3'd7, 1'b0, LSU_STRIDED, LSU_EEW_8, 32'h541, 32'd6, 4, 2'd3);
        wait_idle();
    endtask

    task automatic bus_error();
        // second word of the load and first word of the store hit the fault page
        send_insn(3'd0, 1'b0, LSU_UNITSTRIDE, LSU_EEW_32, 32'h2FFC, 32'd4, 2, 2'd3);
        send_insn(3'd1, 1'b1, LSU_UNITSTRIDE, LSU_EEW_32, 32'h30FC, 32'd4, 2, 2'd3);
        send_insn(3'd2, 1'b0, LSU_UNITSTRIDE, LSU_EEW_32, 32'h600, 32'd4, 1, 2'd3);
        wait_idle();
    endtask

    task automatic back_pressure();
        @(negedge clk);
        hold_mem = 1'b1;
        @(posedge clk);
        #1;
        cpl_ready = 1'b0;
        fork
            begin
                send_insn(3'd3, 1'b0, LSU_UNITSTRIDE, LSU_EEW_32, 32'h700, 32'd4, 3, 2'd3);
                send_insn(3'd4, 1'b1, LSU_UNITSTRIDE, LSU_EEW_32, 32'h800, 32'd4, 2, 2'd0);
            end
            begin
                repeat (6) @(negedge clk);
                check_value("cmd_ready_o", cmd_ready, 1'b0);
                repeat (6) @(negedge clk);
                hold_mem = 1'b0;
            end
        join
        while (exp_res.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("cpl_valid_o", cpl_valid, 1'b1);
        // the oldest completion waits at the port while ready is low
        check_value("cpl_o", cpl, exp_cpls[0]);
        @(posedge clk);
        #1;
        cpl_ready = 1'b1;
        wait_idle();
    endtask

    initial begin
        cmd_valid = 1'b0;
        cmd       = '0;
        cpl_ready = 1'b1;
        rst_n     = 1'b0;
        exp_err   = 1'b0;
        hold_mem  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("mem_valid_o", mem_valid, 1'b0);
        check_value("res_valid_o", res_valid, 1'b0);
        check_value("cpl_valid_o", cpl_valid, 1'b0);
        check_value("cmd_ready_o", cmd_ready, 1'b1);
        @(posedge clk);
        #1;
        unit_stride_store();
        strided_store();
        unit_stride_load();
        strided_load();
        bus_error();
        back_pressure();
        if (exp_reqs.size() != 0 || exp_res.size() != 0 || exp_cpls.size() != 0) begin
            fail_run("expected bus, result or completion traffic never arrived");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* vec_lsu.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/mem_bus_pkg.sv
hdl/lsu_fifo.sv
hdl/lsu_req_stage.sv
hdl/lsu_resp_stage.sv
hdl/vec_lsu.sv
verif/tb_clk_gen.sv
verif/tb_vec_lsu.sv

/* run.sh */
#!/bin/sh
# build the vec_lsu testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_vec_lsu -f vec_lsu.f \
    -o tb_vec_lsu > build.log 2>&1 \
    && ./obj_dir/tb_vec_lsu > sim.log 2>&1
grep -q "^test passed$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
